/* board_counter_defs.svh */
`ifndef BOARD_COUNTER_DEFS_SVH
`define BOARD_COUNTER_DEFS_SVH

// Board widths for the switch register, the buttons and the change counter.

// one LED sits above each slide switch.
`define SW_WIDTH    10

// btn_i[0] captures and btn_i[1] clears.
`define BTN_WIDTH   2

// two hexadecimal digits show the whole count.
`define COUNT_WIDTH 8

// flops between a button pin and the edge detector.
`define SYNC_STAGES 2

`endif

/* board_counter_pkg.sv */
`include "board_counter_defs.svh"

package board_counter_pkg;

  // switch word, also the LED word.
  typedef logic [`SW_WIDTH-1:0] sw_word_t;

  typedef logic [`COUNT_WIDTH-1:0] count_t;  // number of captures that changed the word.

  typedef logic [3:0] digit_t;  // one nibble of the count.

  // active-low segment pattern, bit 0 drives segment a.
  typedef logic [6:0] seg_t;

  // one-cycle press events from the button stage.
  typedef struct packed {
    logic capture;
    logic clear;
  } press_evt_t;

  // output of the capture stage.
  typedef struct packed {
    logic     changed;  // pulses when a capture stored a different word.
    logic     clear;    // the clear press, one cycle later.
    sw_word_t value;    // current content of the switch register.
  } capture_evt_t;

endpackage

/* button_sync.sv */
`timescale 1ns/1ns
`include "board_counter_defs.svh"

module button_sync (
  input  logic                          clk_50MHZ,
  input  logic                          arst_n_i,
  input  logic [`BTN_WIDTH-1:0]         btn_i,
  output board_counter_pkg::press_evt_t press_o
);

  import board_counter_pkg::*;

  // The last stage holds the previous synchronised level for edge detection.
  localparam int unsigned DEPTH = `SYNC_STAGES + 1;

  logic [DEPTH-1:0][`BTN_WIDTH-1:0] sync_q;
  logic [`BTN_WIDTH-1:0]            fall;
  press_evt_t                       press_q;

  always_ff @(posedge clk_50MHZ or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '1;  // buttons read as released.
    end else begin
      sync_q <= {sync_q[DEPTH-2:0], btn_i};
    end
  end

  // a press is a high level followed by a low one in the synchronised chain.
  assign fall = sync_q[DEPTH-1] & ~sync_q[DEPTH-2];

  always_ff @(posedge clk_50MHZ or negedge arst_n_i) begin
    if (!arst_n_i) begin
      press_q <= '0;
    end else begin
      press_q.capture <= fall[0];
      press_q.clear   <= fall[1];
    end
  end

  assign press_o = press_q;

  // A button held low must not produce a second event.
  a_capture_single: assert property (
    @(posedge clk_50MHZ) disable iff (!arst_n_i)
    press_q.capture |=> !press_q.capture
  ) else $error("capture event lasted more than one cycle");

  a_clear_single: assert property (
    @(posedge clk_50MHZ) disable iff (!arst_n_i)
    press_q.clear |=> !press_q.clear
  ) else $error("clear event lasted more than one cycle");

endmodule

/* switch_capture.sv */
`timescale 1ns/1ns

module switch_capture (
  input  logic                            clk_50MHZ,
  input  logic                            arst_n_i,
  input  board_counter_pkg::sw_word_t     sw_i,
  input  board_counter_pkg::press_evt_t   press_i,
  output board_counter_pkg::capture_evt_t cap_o
);

  import board_counter_pkg::*;

  capture_evt_t cap_q;

  always_ff @(posedge clk_50MHZ or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cap_q <= '0;
    end else begin
      cap_q.changed <= 1'b0;
      cap_q.clear   <= press_i.clear;
      if (press_i.clear) begin
        cap_q.value <= '0;  // clear wins over a capture in the same cycle.
      end else if (press_i.capture) begin
        cap_q.value   <= sw_i;
        cap_q.changed <= (sw_i != cap_q.value);
      end
    end
  end

  assign cap_o = cap_q;

  // a clear press empties the register and is never counted as a change.
  a_clear_no_change: assert property (
    @(posedge clk_50MHZ) disable iff (!arst_n_i)
    press_i.clear |=> cap_q.clear && !cap_q.changed && (cap_q.value == '0)
  ) else $error("clear press did not empty the register cleanly");

  // A change is only reported for a capture of a new word.
  a_change_needs_capture: assert property (
    @(posedge clk_50MHZ) disable iff (!arst_n_i)
    cap_q.changed |-> $past(press_i.capture) && (cap_q.value != $past(cap_q.value))
  ) else $error("changed pulse without a new captured word");

endmodule

/* change_counter.sv */
`timescale 1ns/1ns

module change_counter (
  input  logic                            clk_50MHZ,
  input  logic                            arst_n_i,
  input  board_counter_pkg::capture_evt_t cap_i,
  output board_counter_pkg::count_t       count_o
);

  import board_counter_pkg::*;

  count_t count_q;

  always_ff @(posedge clk_50MHZ or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (cap_i.clear) begin
      count_q <= '0;
    end else if (cap_i.changed) begin
      count_q <= count_q + 1'b1;  // wraps from 255 to 0.
    end
  end

  assign count_o = count_q;

  // The count moves by one step on a change, or drops to zero on a clear.
  a_count_step: assert property (
    @(posedge clk_50MHZ) disable iff (!arst_n_i)
    (count_q != $past(count_q)) |->
      ((count_q == count_t'($past(count_q) + 1'b1)) && $past(cap_i.changed))
      || ((count_q == '0) && $past(cap_i.clear))
  ) else $error("count changed by something other than one step or a clear");

endmodule

/* hex_display.sv */
`timescale 1ns/1ns

module hex_display (
  input  logic                      clk_50MHZ,
  input  logic                      arst_n_i,
  input  board_counter_pkg::count_t count_i,
  output board_counter_pkg::seg_t   hex0_o,
  output board_counter_pkg::seg_t   hex1_o
);

  import board_counter_pkg::*;

  localparam seg_t SEG_ZERO = 7'b100_0000;

  digit_t lo_nib;
  digit_t hi_nib;
  seg_t   hex0_q;
  seg_t   hex1_q;

  // Active-low hexadecimal table, segment a in bit 0.
  function automatic seg_t hex_to_seg(input digit_t d);
    seg_t s;
    case (d)
      4'h0:    s = SEG_ZERO;
      4'h1:    s = 7'b111_1001;
      4'h2:    s = 7'b010_0100;
      4'h3:    s = 7'b011_0000;
      4'h4:    s = 7'b001_1001;
      4'h5:    s = 7'b001_0010;
      4'h6:    s = 7'b000_0010;
      4'h7:    s = 7'b111_1000;
      4'h8:    s = 7'b000_0000;
      4'h9:    s = 7'b001_0000;
      4'ha:    s = 7'b000_1000;
      4'hb:    s = 7'b000_0011;
      4'hc:    s = 7'b100_0110;
      4'hd:    s = 7'b010_0001;
      4'he:    s = 7'b000_0110;
      default: s = 7'b000_1110;  // f.
    endcase
    return s;
  endfunction

  assign {hi_nib, lo_nib} = count_i;

  always_ff @(posedge clk_50MHZ or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hex0_q <= SEG_ZERO;  // both digits show 0 out of reset.
      hex1_q <= SEG_ZERO;
    end else begin
      hex0_q <= hex_to_seg(lo_nib);
      hex1_q <= hex_to_seg(hi_nib);
    end
  end

  assign hex0_o = hex0_q;
  assign hex1_o = hex1_q;

  // the digits stay known on every cycle once reset is released.
  a_digits_known: assert property (
    @(posedge clk_50MHZ) disable iff (!arst_n_i)
    !$isunknown({hex1_q, hex0_q})
  ) else $error("seven-segment outputs went unknown");

endmodule

/* board_counter_top.sv */
`timescale 1ns/1ns
`include "board_counter_defs.svh"

module board_counter_top (
  input  logic                        clk_50MHZ,
  input  logic                        arst_n_i,
  input  board_counter_pkg::sw_word_t sw_i,
  input  logic [`BTN_WIDTH-1:0]       btn_i,   // active low.
  output board_counter_pkg::sw_word_t led_o,
  output board_counter_pkg::seg_t     hex0_o,  // low nibble.
  output board_counter_pkg::seg_t     hex1_o   // high nibble.
);

  import board_counter_pkg::*;

  press_evt_t   press;
  capture_evt_t cap;
  count_t       count;

  button_sync button_sync_i (
    .clk_50MHZ (clk_50MHZ),
    .arst_n_i  (arst_n_i),
    .btn_i     (btn_i),
    .press_o   (press)
  );

  switch_capture switch_capture_i (
    .clk_50MHZ (clk_50MHZ),
    .arst_n_i  (arst_n_i),
    .sw_i      (sw_i),
    .press_i   (press),
    .cap_o     (cap)
  );

  change_counter change_counter_i (
    .clk_50MHZ (clk_50MHZ),
    .arst_n_i  (arst_n_i),
    .cap_i     (cap),
    .count_o   (count)
  );

  hex_display hex_display_i (
    .clk_50MHZ (clk_50MHZ),
    .arst_n_i  (arst_n_i),
    .count_i   (count),
    .hex0_o    (hex0_o),
    .hex1_o    (hex1_o)
  );

  assign led_o = cap.value;  // the LEDs mirror the stored switch word.

endmodule

/* tb_board_counter.sv */
`timescale 1ns/1ns
`include "board_counter_defs.svh"

module tb_board_counter;

  import board_counter_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int DRIVE_DELAY     = 2;
  localparam int RESET_CYCLES    = 5;
  localparam int HOLD_CYCLES     = 4;
  localparam int SETTLE_CYCLES   = 2;    // hold plus settle covers the 6-cycle latency.
  localparam int PLANNED_PRESSES = 304;
  localparam int WATCHDOG_CYCLES = PLANNED_PRESSES * 12 + 100;

  localparam logic [`BTN_WIDTH-1:0] CAPTURE_BTN = 2'b01;
  localparam logic [`BTN_WIDTH-1:0] CLEAR_BTN   = 2'b10;
  localparam logic [`BTN_WIDTH-1:0] BOTH_BTN    = 2'b11;

  // standard active-low hexadecimal patterns, segment a in bit 0.
  localparam seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic                  clk_50MHZ = 1'b0;
  logic                  arst_n;
  sw_word_t              sw;
  logic [`BTN_WIDTH-1:0] btn;
  sw_word_t              led;
  seg_t                  hex0;
  seg_t                  hex1;

  sw_word_t    model_reg;
  count_t      model_count;
  logic [31:0] rng_state;

  board_counter_top board_counter_top_i (
    .clk_50MHZ (clk_50MHZ),
    .arst_n_i  (arst_n),
    .sw_i      (sw),
    .btn_i     (btn),
    .led_o     (led),
    .hex0_o    (hex0),
    .hex1_o    (hex1)
  );

  always #(CLK_PERIOD / 2) clk_50MHZ = ~clk_50MHZ;

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input sw_word_t expected, input sw_word_t actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  // the count is only visible on the pins as two decoded digits.
  task automatic check_count(input count_t expected);
    check_seg("hex0_o", SEG_TABLE[expected[3:0]], hex0);
    check_seg("hex1_o", SEG_TABLE[expected[7:4]], hex1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic sw_word_t next_switch_word();
    rng_state = xorshift32(rng_state);
    return rng_state[`SW_WIDTH-1:0];
  endfunction

  // moves to a small delay after the n-th following rising edge.
  task automatic step(input int n);
    repeat (n) @(posedge clk_50MHZ);
    #DRIVE_DELAY;
  endtask

  task automatic update_model(input logic [`BTN_WIDTH-1:0] pressed, input sw_word_t word);
    if (pressed[1]) begin
      model_reg   = '0;  // clear wins over a simultaneous capture.
      model_count = '0;
    end else if (pressed[0]) begin
      if (word != model_reg) begin
        model_count = model_count + 1'b1;
      end
      model_reg = word;
    end
  endtask

  task automatic press_buttons(input logic [`BTN_WIDTH-1:0] pressed, input sw_word_t word);
    sw  = word;
    btn = ~pressed;
    step(HOLD_CYCLES);
    btn = '1;
    step(SETTLE_CYCLES);
    update_model(pressed, word);
    check_word("led_o", model_reg, led);
    check_count(model_count);
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    btn    = '1;
    sw     = '0;
    repeat (RESET_CYCLES) @(posedge clk_50MHZ);
    #DRIVE_DELAY;
    arst_n      = 1'b1;
    model_reg   = '0;
    model_count = '0;
    step(1);
  endtask

  task automatic test_reset_state();
    check_word("led_o", '0, led);
    check_count('0);
  endtask

  task automatic test_capture_latency();
    sw_word_t old_word;
    count_t   old_count;
    sw_word_t long_word;
    old_word  = model_reg;
    old_count = model_count;
    sw  = 10'h2a5;
    btn = ~CAPTURE_BTN;
    step(3);
    check_word("led_o", old_word, led);
    step(1);
    update_model(CAPTURE_BTN, 10'h2a5);
    check_word("led_o", model_reg, led);
    btn = '1;
    step(1);
    check_count(old_count);
    step(1);
    check_count(model_count);
    // a held button with a moving switch word must still capture once.
    long_word = 10'h15a;
    sw  = long_word;
    btn = ~CAPTURE_BTN;
    step(6);
    sw = 10'h3c3;
    step(6);
    btn = '1;
    step(SETTLE_CYCLES);
    update_model(CAPTURE_BTN, long_word);
    check_word("led_o", long_word, led);
    check_count(model_count);
  endtask

  task automatic test_random_changes();
    for (int i = 0; i < 40; i++) begin
      press_buttons(CAPTURE_BTN, next_switch_word());
    end
  endtask

  task automatic test_repeated_value();
    count_t saved;
    press_buttons(CAPTURE_BTN, 10'h0f0);
    saved = model_count;
    press_buttons(CAPTURE_BTN, 10'h0f0);
    check_count(saved);
  endtask

  task automatic test_clear();
    press_buttons(CLEAR_BTN, 10'h1ff);
    check_word("led_o", '0, led);
    check_count('0);
    press_buttons(CAPTURE_BTN, 10'h0ff);
    press_buttons(BOTH_BTN, 10'h321);
    check_word("led_o", '0, led);
    check_count('0);
  endtask

  task automatic test_wrap();
    press_buttons(CLEAR_BTN, '0);
    for (int i = 0; i < 256; i++) begin
      press_buttons(CAPTURE_BTN, i[0] ? 10'h2aa : 10'h155);
      if (i == 254) begin
        check_count(8'hff);
      end
    end
    check_count(8'h00);  // 256 changes bring the count back round to zero.
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_50MHZ);
    $display("simulation timed out after %0d clock cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  initial begin
    arst_n    = 1'b0;
    btn       = '1;
    sw        = '0;
    rng_state = 32'd30729;
    apply_reset();
    test_reset_state();
    test_capture_latency();
    test_random_changes();
    test_repeated_value();
    test_clear();
    test_wrap();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* board_counter.f */
+incdir+.
board_counter_pkg.sv
button_sync.sv
switch_capture.sv
change_counter.sv
hex_display.sv
board_counter_top.sv
tb_board_counter.sv
